// ==== design/eg_glue_top.sv ====
// Emulator glue top level

`timescale 1ns/1ps

module eg_glue_top import kbd_pkg::*, video_pkg::*; #(
	parameter int TICK_W = TICK_W_DEF
) (
	input  logic               clk_sys,
	input  logic               rst,
	input  logic               reset_req,
	input  logic               paste_req,
	input  logic [FNAME_W-1:0] fname,
	input  key_event_t         host_key,
	input  logic               ce_pix,
	input  logic               pixel,
	input  color_idx_t         color,
	input  logic               hsync,
	input  logic               vsync,
	input  logic               hblank,
	input  logic               vblank,
	output key_event_t         key_out,
	output logic               paste_active,
	output rgb_ch_t            r,
	output rgb_ch_t            g,
	output rgb_ch_t            b,
	output logic               hs,
	output logic               vs,
	output logic               de,
	output logic               ce_out
);

	logic      core_rst;
	char_t     char_cur;
	logic      char_next;
	scancode_t code;
	logic      needs_shift;

	////////////////////////////////////////
	// Reset and paste path
	power_hold u_power_hold (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.reset_req (reset_req),
		.core_rst  (core_rst)
	);

	paste_capture u_paste_capture (
		.clk_sys      (clk_sys),
		.core_rst     (core_rst),
		.paste_req    (paste_req),
		.fname        (fname),
		.char_next    (char_next),
		.char_cur     (char_cur),
		.char_valid   (),              // Same as paste_active here
		.paste_active (paste_active)
	);

	scancode_map u_scancode_map (
		.clk_sys     (clk_sys),
		.core_rst    (core_rst),
		.char_cur    (char_cur),
		.code        (code),
		.needs_shift (needs_shift)
	);

	key_sequencer #(.TICK_W(TICK_W)) u_key_sequencer (
		.clk_sys      (clk_sys),
		.core_rst     (core_rst),
		.paste_active (paste_active),
		.code         (code),
		.needs_shift  (needs_shift),
		.host_key     (host_key),
		.char_next    (char_next),
		.key_out      (key_out)
	);

	// Video colour path
	palette_stage u_palette_stage (
		.clk_sys  (clk_sys),
		.core_rst (core_rst),
		.ce_pix   (ce_pix),
		.pixel    (pixel),
		.color    (color),
		.hsync    (hsync),
		.vsync    (vsync),
		.hblank   (hblank),
		.vblank   (vblank),
		.r        (r),
		.g        (g),
		.b        (b),
		.hs       (hs),
		.vs       (vs),
		.de       (de),
		.ce_out   (ce_out)
	);

endmodule

// ==== design/kbd_pkg.sv ====
// Keyboard paste definitions

package kbd_pkg;

	////////////////////////////////////////
	// Key event word layout
	localparam int KEY_W          = 11;
	localparam int KEY_TOGGLE_BIT = 10;     // Flips on each new event
	localparam int KEY_PRESS_BIT  = 9;      // Set for press, clear for release
	localparam int KEY_EXT_BIT    = 8;      // Extended prefix, never set when pasting
	localparam int CODE_W         = 8;

	// Filename as latched by the tape loader
	localparam int CHAR_W      = 8;
	localparam int FNAME_CHARS = 6;
	localparam int FNAME_W     = FNAME_CHARS * CHAR_W;  // First char in top byte

	localparam int TICK_W_DEF  = 21;        // Roughly 2M clocks per event
	localparam int HOLD_CYCLES = 32;        // Core reset stretch

	localparam logic [CODE_W-1:0] SC_LSHIFT = 8'h12;
	localparam logic [CODE_W-1:0] SC_NONE   = 8'h00;
	localparam logic [CODE_W-1:0] SC_MINUS  = 8'h4E;  // Shifted gives *

	typedef logic [KEY_W-1:0]  key_event_t;
	typedef logic [CODE_W-1:0] scancode_t;
	typedef logic [CHAR_W-1:0] char_t;

	////////////////////////////////////////
	// ASCII to set-2 scancode
	function automatic scancode_t char_code(input char_t c);
		case (c)
			8'h20: return 8'h29;    // Space
			8'h2A: return SC_MINUS;
			8'h2E: return 8'h49;
			8'h30: return 8'h45;
			8'h31: return 8'h16;
			8'h32: return 8'h1E;
			8'h33: return 8'h26;
			8'h34: return 8'h25;
			8'h35: return 8'h2E;
			8'h36: return 8'h36;
			8'h37: return 8'h3D;
			8'h38: return 8'h3E;
			8'h39: return 8'h46;
			8'h40: return 8'h54;    // @
			8'h41: return 8'h1C;
			8'h42: return 8'h32;
			8'h43: return 8'h21;
			8'h44: return 8'h23;
			8'h45: return 8'h24;
			8'h46: return 8'h2B;
			8'h47: return 8'h34;
			8'h48: return 8'h33;
			8'h49: return 8'h43;
			8'h4A: return 8'h3B;
			8'h4B: return 8'h42;
			8'h4C: return 8'h4B;
			8'h4D: return 8'h3A;
			8'h4E: return 8'h31;
			8'h4F: return 8'h44;
			8'h50: return 8'h4D;
			8'h51: return 8'h15;
			8'h52: return 8'h2D;
			8'h53: return 8'h1B;
			8'h54: return 8'h2C;
			8'h55: return 8'h3C;
			8'h56: return 8'h2A;
			8'h57: return 8'h1D;
			8'h58: return 8'h22;
			8'h59: return 8'h35;
			8'h5A: return 8'h1A;
			default: return SC_NONE;  // Not typeable
		endcase
	endfunction

	// Only * needs left shift held
	function automatic logic char_shift(input char_t c);
		return (c == 8'h2A);
	endfunction

endpackage

// ==== design/key_sequencer.sv ====
// Paste key event sequencer

`timescale 1ns/1ps

module key_sequencer import kbd_pkg::*; #(
	parameter int TICK_W = TICK_W_DEF  // Event spacing is 2**TICK_W clocks
) (
	input  logic       clk_sys,
	input  logic       core_rst,
	input  logic       paste_active,
	input  scancode_t  code,
	input  logic       needs_shift,
	input  key_event_t host_key,
	output logic       char_next,
	output key_event_t key_out
);

	logic [TICK_W-1:0] tick_cnt;
	logic              tick;
	logic [1:0]        phase;        // Event index within current char
	logic              last_ev;
	logic              ev_press;
	scancode_t         ev_code;
	key_event_t        ev_word;

	////////////////////////////////////////
	// Tick timer
	always_ff @(posedge clk_sys) begin
		if (core_rst || !paste_active)
			tick_cnt <= '0;    // Restart with each paste
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	assign tick = paste_active & (&tick_cnt);

	// Event decode
	// Plain key is press, release; shifted key is
	// shift press, key press, key release, shift release
	always_comb begin
		if (needs_shift) begin
			last_ev  = (phase == 2'd3);
			ev_press = (phase < 2'd2);
			ev_code  = (phase == 2'd0 || phase == 2'd3) ? SC_LSHIFT : code;
		end else begin
			last_ev  = (phase == 2'd1);
			ev_press = (phase == 2'd0);
			ev_code  = code;
		end
	end

	// Phase counter
	always_ff @(posedge clk_sys) begin
		if (core_rst || !paste_active)
			phase <= 2'd0;
		else if (tick)
			phase <= last_ev ? 2'd0 : phase + 2'd1;
	end

	assign char_next = tick & last_ev;  // Last event of this char goes out now

	always_comb begin
		ev_word                 = '0;
		ev_word[KEY_TOGGLE_BIT] = ~key_out[KEY_TOGGLE_BIT];  // New event
		ev_word[KEY_PRESS_BIT]  = ev_press;
		ev_word[KEY_EXT_BIT]    = 1'b0;
		ev_word[CODE_W-1:0]     = ev_code;
	end

	////////////////////////////////////////
	// Output select
	always_ff @(posedge clk_sys) begin
		if (core_rst)
			key_out <= '0;
		else if (!paste_active)
			key_out <= host_key;     // Passthrough, one clock late
		else if (tick)
			key_out <= ev_word;
	end

	// During a paste the keyboard only sees new events on ticks
	assert property (@(posedge clk_sys) disable iff (core_rst)
		$past(paste_active) && $changed(key_out[KEY_TOGGLE_BIT]) |-> $past(tick))
		else $error("toggle bit moved between ticks");

	assert property (@(posedge clk_sys) disable iff (core_rst)
		char_next |=> !char_next)
		else $error("char_next wider than one clock");

endmodule

// ==== design/palette_stage.sv ====
// Palette lookup pipeline

`timescale 1ns/1ps

module palette_stage import video_pkg::*; (
	input  logic       clk_sys,
	input  logic       core_rst,
	input  logic       ce_pix,
	input  logic       pixel,       // Foreground bit
	input  color_idx_t color,
	input  logic       hsync,
	input  logic       vsync,
	input  logic       hblank,
	input  logic       vblank,
	output rgb_ch_t    r,
	output rgb_ch_t    g,
	output rgb_ch_t    b,
	output logic       hs,
	output logic       vs,
	output logic       de,
	output logic       ce_out
);

	pal_entry_t entry_q;   // Stage one palette word
	logic       pix_q;
	logic       blank_q;
	logic       hs_q;
	logic       vs_q;
	logic       ce_q;
	logic       show;

	////////////////////////////////////////
	// Stage one, table read
	always_ff @(posedge clk_sys)
		entry_q <= PALETTE[color];

	always_ff @(posedge clk_sys) begin
		if (core_rst) begin
			pix_q   <= 1'b0;
			blank_q <= 1'b1;     // Blanked out of reset
			hs_q    <= 1'b0;
			vs_q    <= 1'b0;
			ce_q    <= 1'b0;
		end else begin
			pix_q   <= pixel;
			blank_q <= hblank | vblank;
			hs_q    <= hsync;
			vs_q    <= vsync;
			ce_q    <= ce_pix;
		end
	end

	assign show = pix_q & ~blank_q;

	////////////////////////////////////////
	// Stage two, gate and widen to 8 bits
	always_ff @(posedge clk_sys) begin
		if (core_rst) begin
			r      <= '0;
			g      <= '0;
			b      <= '0;
			hs     <= 1'b0;
			vs     <= 1'b0;
			de     <= 1'b0;
			ce_out <= 1'b0;
		end else begin
			r      <= show ? {entry_q[PAL_W-1 -: PAL_CH_W], 2'b00} : '0;
			g      <= show ? {entry_q[2*PAL_CH_W-1 -: PAL_CH_W], 2'b00} : '0;
			b      <= show ? {entry_q[PAL_CH_W-1:0], 2'b00} : '0;
			hs     <= hs_q;
			vs     <= vs_q;
			de     <= ~blank_q;
			ce_out <= ce_q;
		end
	end

	// Blanking must reach de with the same two clocks as colour
	assert property (@(posedge clk_sys) disable iff (core_rst)
		$past(hblank, 2) || $past(vblank, 2) |-> !de)
		else $error("de high in blanking");

endmodule

// ==== design/paste_capture.sv ====
// Filename paste capture

`timescale 1ns/1ps

module paste_capture import kbd_pkg::*; (
	input  logic               clk_sys,
	input  logic               core_rst,
	input  logic               paste_req,    // Level from host menu
	input  logic [FNAME_W-1:0] fname,
	input  logic               char_next,    // All events of char_cur sent
	output char_t              char_cur,
	output logic               char_valid,
	output logic               paste_active
);

	localparam int POS_W = $clog2(FNAME_CHARS);

	logic               req_d;
	logic               req_rise;
	logic               start;
	logic [FNAME_W-1:0] name_sr;    // Current char always on top
	logic [POS_W-1:0]   pos;

	assign req_rise = paste_req & ~req_d;
	assign start    = req_rise & ~paste_active;  // Edges mid paste are dropped

	// Request delay for edge detect
	always_ff @(posedge clk_sys)
		req_d <= paste_req;

	////////////////////////////////////////
	// Paste control
	always_ff @(posedge clk_sys) begin
		if (core_rst) begin
			paste_active <= 1'b0;
			pos          <= '0;
		end else if (start) begin
			paste_active <= 1'b1;
			pos          <= '0;
		end else if (paste_active && char_next) begin
			pos <= pos + 1'b1;
			if (pos == POS_W'(FNAME_CHARS - 1))
				paste_active <= 1'b0;    // Sixth char done
		end
	end

	// Name shifter
	always_ff @(posedge clk_sys) begin
		if (start)
			name_sr <= fname;
		else if (char_next)
			name_sr <= {name_sr[FNAME_W-CHAR_W-1:0], CHAR_W'(0)};
	end

	assign char_cur   = name_sr[FNAME_W-1 -: CHAR_W];
	assign char_valid = paste_active;

	// Sequencer may only step while a paste runs
	assert property (@(posedge clk_sys) disable iff (core_rst)
		char_next |-> paste_active)
		else $error("char_next outside paste");

endmodule

// ==== design/power_hold.sv ====
// Core reset stretcher

`timescale 1ns/1ps

module power_hold import kbd_pkg::*; (
	input  logic clk_sys,
	input  logic rst,
	input  logic reset_req,     // Host menu reset
	output logic core_rst
);

	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	logic [CNT_W-1:0] hold_cnt;
	logic             src_rst;

	assign src_rst = rst | reset_req;  // Either source restarts the hold

	// Reload while any source is up, then count out
	always_ff @(posedge clk_sys) begin
		if (src_rst) begin
			hold_cnt <= CNT_W'(HOLD_CYCLES);
			core_rst <= 1'b1;
		end else begin
			if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			core_rst <= (hold_cnt != '0);  // Drops on the cycle the count runs out
		end
	end

	// Released core reset must have seen a full hold since the last source
	assert property (@(posedge clk_sys)
		$fell(core_rst) |-> !$past(src_rst, 1) && !$past(src_rst, HOLD_CYCLES))
		else $error("core_rst released early");

endmodule

// ==== design/scancode_map.sv ====
// Character to scancode translation

`timescale 1ns/1ps

module scancode_map import kbd_pkg::*; (
	input  logic      clk_sys,
	input  logic      core_rst,
	input  char_t     char_cur,
	output scancode_t code,
	output logic      needs_shift   // Wrap key in LSHIFT press and release
);

	scancode_t code_nxt;
	logic      shift_nxt;

	// Lookup from the package table
	always_comb begin
		code_nxt  = char_code(char_cur);
		shift_nxt = char_shift(char_cur);
	end

	////////////////////////////////////////
	// One register stage without strobe
	// Sequencer reads only at ticks that come two or more clocks after the char moved
	always_ff @(posedge clk_sys) begin
		if (core_rst) begin
			code        <= SC_NONE;
			needs_shift <= 1'b0;
		end else begin
			code        <= code_nxt;
			needs_shift <= shift_nxt;
		end
	end

endmodule

// ==== design/video_pkg.sv ====
// Video palette definitions

package video_pkg;

	localparam int IDX_W    = 4;
	localparam int PAL_CH_W = 6;
	localparam int PAL_W    = 3 * PAL_CH_W;    // R, G, B from top
	localparam int RGB_CH_W = 8;

	typedef logic [IDX_W-1:0]    color_idx_t;
	typedef logic [PAL_W-1:0]    pal_entry_t;
	typedef logic [RGB_CH_W-1:0] rgb_ch_t;

	////////////////////////////////////////
	// Fixed 16 colour palette, index order
	localparam pal_entry_t PALETTE [0:15] = '{
		18'b010111_010111_010111,   // 0 dark grey
		18'b011011_111111_111010,   // 1 cyan
		18'b110010_001001_010111,   // 2 red
		18'b111010_111010_111010,   // 3 light grey
		18'b111111_111100_001111,   // 4 yellow
		18'b101010_111111_010010,   // 5 green
		18'b111010_011011_001010,   // 6 orange
		18'b111010_111111_001001,   // 7 yellow green
		18'b001011_010100_111111,   // 8 blue
		18'b101111_110111_111111,   // 9 light blue
		18'b110001_010011_111111,   // 10 pink
		18'b100010_011001_111111,   // 11 violet
		18'b100011_100011_100011,   // 12 grey
		18'b000111_110001_100011,   // 13 turquoise
		18'b100110_001000_111111,   // 14 magenta
		18'b111111_111111_111111    // 15 white
	};

endpackage

// ==== tb.f ====
design/kbd_pkg.sv
design/video_pkg.sv
design/power_hold.sv
design/paste_capture.sv
design/scancode_map.sv
design/key_sequencer.sv
design/palette_stage.sv
design/eg_glue_top.sv
verif/tb_eg_glue.sv

// ==== verif/tb_eg_glue.sv ====
// Emulator glue testbench

`timescale 1ns/1ps

module tb_eg_glue import kbd_pkg::*, video_pkg::*; ();

	localparam int TICK_W_TB   = 4;
	localparam int TICK_LEN    = 1 << TICK_W_TB;
	localparam int N_PASTE     = 3;
	localparam int N_VID       = 8;
	localparam int N_RAND      = 24;
	// Every paste plus the aborted one with all chars shifted
	localparam int CYCLE_LIMIT = (N_PASTE + 1) * FNAME_CHARS * 4 * TICK_LEN + 2000;

	////////////////////////////////////////
	// Paste cases with codes in name order
	localparam logic [FNAME_W-1:0] PASTE_NAME [N_PASTE] = '{"AB12CD", "GAME07", "R*N#S."};
	localparam scancode_t PASTE_CODES [N_PASTE][FNAME_CHARS] = '{
		'{8'h1C, 8'h32, 8'h16, 8'h1E, 8'h21, 8'h23},
		'{8'h34, 8'h1C, 8'h3A, 8'h24, 8'h45, 8'h3D},
		'{8'h2D, 8'h4E, 8'h31, 8'h00, 8'h1B, 8'h49}   // # is unmapped
	};
	localparam logic [FNAME_CHARS-1:0] PASTE_SHIFT [N_PASTE] = '{6'b000000, 6'b000000, 6'b010000};
	localparam logic PASTE_RETRIG [N_PASTE] = '{1'b0, 1'b0, 1'b1};  // Extra request mid paste

	// Video cases with expected RGB packed as r g b
	localparam color_idx_t VID_COLOR [N_VID] = '{4'd1, 4'd2, 4'd15, 4'd8, 4'd0, 4'd15, 4'd4, 4'd9};
	localparam logic VID_PIX [N_VID] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
	localparam logic VID_HB  [N_VID] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
	localparam logic VID_VB  [N_VID] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
	localparam logic [23:0] VID_RGB [N_VID] = '{
		24'h6CFCE8, 24'hC8245C, 24'hFCFCFC, 24'h2C50FC,
		24'h5C5C5C, 24'h000000, 24'h000000, 24'h000000
	};

	logic               clk_sys;
	logic               rst;
	logic               reset_req;
	logic               paste_req;
	logic [FNAME_W-1:0] fname;
	key_event_t         host_key;
	logic               ce_pix;
	logic               pixel;
	color_idx_t         color;
	logic               hsync;
	logic               vsync;
	logic               hblank;
	logic               vblank;
	key_event_t         key_out;
	logic               paste_active;
	rgb_ch_t            r;
	rgb_ch_t            g;
	rgb_ch_t            b;
	logic               hs;
	logic               vs;
	logic               de;
	logic               ce_out;

	int          n_checks  = 0;
	int          n_errors  = 0;
	int          cycle_cnt = 0;
	logic [31:0] lfsr      = 32'h3f8a;
	logic [27:0] vid_q [$];   // {r, g, b, hs, vs, de, ce} per pixel in flight
	color_idx_t  rand_col [N_RAND];

	eg_glue_top #(.TICK_W(TICK_W_TB)) dut (
		.clk_sys(clk_sys), .rst(rst), .reset_req(reset_req), .paste_req(paste_req),
		.fname(fname), .host_key(host_key), .ce_pix(ce_pix), .pixel(pixel),
		.color(color), .hsync(hsync), .vsync(vsync), .hblank(hblank), .vblank(vblank),
		.key_out(key_out), .paste_active(paste_active), .r(r), .g(g), .b(b),
		.hs(hs), .vs(vs), .de(de), .ce_out(ce_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;  // 25 MHz
	end

	// Run limit
	initial begin
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("*** FAILED ***");
		$finish;
	end

	////////////////////////////////////////
	// Helpers

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			val  = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	function automatic key_event_t make_event(input logic press, input scancode_t code);
		return {1'b0, press, 1'b0, code};   // Toggle filled in at compare
	endfunction

	// Palette channel (0 r, 1 g, 2 b) with two zero LSBs
	function automatic rgb_ch_t pal_channel(input color_idx_t c, input int ch);
		return {PALETTE[c][PAL_W-1-ch*PAL_CH_W -: PAL_CH_W], 2'b00};
	endfunction

	task automatic check_key(input key_event_t got, input key_event_t want, input string what);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, want);
		end
	endtask

	task automatic check_rgb(input rgb_ch_t got_r, input rgb_ch_t got_g, input rgb_ch_t got_b,
			input rgb_ch_t want_r, input rgb_ch_t want_g, input rgb_ch_t want_b,
			input string what);
		n_checks++;
		if ({got_r, got_g, got_b} !== {want_r, want_g, want_b}) begin
			n_errors++;
			$display("[FAIL] %0t ns: %s got %h_%h_%h expected %h_%h_%h", $time, what,
				got_r, got_g, got_b, want_r, want_g, want_b);
		end
	endtask

	task automatic check_bit(input logic got, input logic want, input string what);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("[FAIL] %0t ns: %s got %b expected %b", $time, what, got, want);
		end
	endtask

	////////////////////////////////////////
	// Host passthrough checked one clock late
	task automatic host_passthrough(input int n);
		key_event_t sent;
		@(negedge clk_sys);
		host_key = key_event_t'(rand_bits(KEY_W));
		sent     = host_key;
		for (int i = 0; i < n; i++) begin
			@(negedge clk_sys);
			check_key(key_out, sent, "host key passthrough");
			host_key = key_event_t'(rand_bits(KEY_W));
			sent     = host_key;
		end
	endtask

	// One filename paste with events checked as they appear
	task automatic run_paste(input int idx);
		key_event_t exp_q [$];
		key_event_t want;
		key_event_t last;
		scancode_t  c;
		int         n_ev;
		int         gap;
		logic       done;
		for (int i = 0; i < FNAME_CHARS; i++) begin
			c = PASTE_CODES[idx][i];
			if (PASTE_SHIFT[idx][FNAME_CHARS-1-i]) begin
				exp_q.push_back(make_event(1'b1, SC_LSHIFT));
				exp_q.push_back(make_event(1'b1, c));
				exp_q.push_back(make_event(1'b0, c));
				exp_q.push_back(make_event(1'b0, SC_LSHIFT));
			end else begin
				exp_q.push_back(make_event(1'b1, c));
				exp_q.push_back(make_event(1'b0, c));
			end
		end
		@(negedge clk_sys);
		fname     = PASTE_NAME[idx];
		paste_req = 1'b1;
		last      = key_out;
		@(negedge clk_sys);
		paste_req = 1'b0;
		check_bit(paste_active, 1'b1, "paste_active after request edge");
		n_ev = 0;
		gap  = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk_sys);
			paste_req = 1'b0;
			gap++;
			if (key_out !== last) begin   // New event flips the toggle bit
				if (n_ev < exp_q.size()) begin
					want                 = exp_q[n_ev];
					want[KEY_TOGGLE_BIT] = ~last[KEY_TOGGLE_BIT];
					check_key(key_out, want, "pasted key event");
				end
				n_checks++;
				if (gap != TICK_LEN) begin
					n_errors++;
					$display("[FAIL] %0t ns: pasted event %0d came %0d clocks late, expected %0d",
						$time, n_ev, gap, TICK_LEN);
				end
				gap = 0;
				n_ev++;
				last = key_out;
				if (PASTE_RETRIG[idx] && n_ev == 3)
					paste_req = 1'b1;           // Should be ignored
			end
			done = !paste_active;
		end
		if (n_ev != exp_q.size()) begin
			n_errors++;
			$display("Paste case %0d produced %0d key events instead of %0d",
				idx, n_ev, exp_q.size());
		end
		repeat (3) begin
			@(negedge clk_sys);
			check_bit(paste_active, 1'b0, "paste_active after paste end");
		end
	endtask

	// Drive one pixel and check the one from two clocks back
	task automatic video_step(input color_idx_t c, input logic pix, input logic hb,
			input logic vb, input logic [23:0] want_rgb);
		logic [27:0] want;
		@(negedge clk_sys);
		if (vid_q.size() == 2) begin
			want = vid_q.pop_front();
			check_rgb(r, g, b, want[27:20], want[19:12], want[11:4], "palette RGB");
			check_bit(hs, want[3], "hs");
			check_bit(vs, want[2], "vs");
			check_bit(de, want[1], "de");
			check_bit(ce_out, want[0], "ce_out");
		end
		color  = c;
		pixel  = pix;
		hblank = hb;
		vblank = vb;
		hsync  = 1'(rand_bits(1));
		vsync  = 1'(rand_bits(1));
		ce_pix = 1'(rand_bits(1));
		vid_q.push_back({want_rgb, hsync, vsync, ~(hb | vb), ce_pix});
	endtask

	task automatic video_flush();
		video_step('0, 1'b0, 1'b0, 1'b0, '0);
		video_step('0, 1'b0, 1'b0, 1'b0, '0);
		vid_q.delete();
	endtask

	// Reset request in the middle of a paste
	task automatic reset_during_paste();
		key_event_t last;
		int         seen;
		int         wait_cnt;
		@(negedge clk_sys);
		fname     = PASTE_NAME[0];
		paste_req = 1'b1;
		last      = key_out;
		@(negedge clk_sys);
		paste_req = 1'b0;
		seen      = 0;
		while (seen < 2) begin
			@(negedge clk_sys);
			if (key_out !== last) begin
				seen++;
				last = key_out;
			end
		end
		host_key  = key_event_t'(rand_bits(KEY_W)) | 11'h001;   // Never zero
		reset_req = 1'b1;
		@(negedge clk_sys);
		reset_req = 1'b0;
		for (int i = 0; i < HOLD_CYCLES; i++) begin
			@(negedge clk_sys);
			check_key(key_out, '0, "key_out during core reset hold");
			check_bit(paste_active, 1'b0, "paste_active during core reset hold");
		end
		wait_cnt = 0;
		while (key_out !== host_key && wait_cnt < 8) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		if (key_out !== host_key) begin
			n_errors++;
			$display("Host passthrough did not resume after the core reset hold");
		end
		check_bit(paste_active, 1'b0, "paste_active after core reset");
	endtask

	////////////////////////////////////////
	// Main sequence
	initial begin
		rst       = 1'b1;
		reset_req = 1'b0;
		paste_req = 1'b0;
		fname     = '0;
		host_key  = '0;
		ce_pix    = 1'b0;
		pixel     = 1'b0;
		color     = '0;
		hsync     = 1'b0;
		vsync     = 1'b0;
		hblank    = 1'b0;
		vblank    = 1'b0;
		repeat (3) @(negedge clk_sys);
		rst = 1'b0;
		@(negedge clk_sys);
		check_key(key_out, '0, "key_out after reset");
		check_bit(paste_active, 1'b0, "paste_active after reset");
		check_bit(de, 1'b0, "de after reset");
		repeat (HOLD_CYCLES + 2) @(negedge clk_sys);   // Core reset released

		host_passthrough(16);
		for (int i = 0; i < N_PASTE; i++)
			run_paste(i);

		for (int i = 0; i < N_VID; i++)
			video_step(VID_COLOR[i], VID_PIX[i], VID_HB[i], VID_VB[i], VID_RGB[i]);
		video_flush();
		for (int i = 0; i < N_RAND; i++) begin
			rand_col[i] = color_idx_t'(rand_bits(IDX_W));
			video_step(rand_col[i], 1'b1, 1'b0, 1'b0, {pal_channel(rand_col[i], 0),
				pal_channel(rand_col[i], 1), pal_channel(rand_col[i], 2)});
		end
		// Same colours now hidden by pixel or a blank
		for (int i = 0; i < N_RAND; i++)
			video_step(rand_col[i], i % 3 != 0, i % 3 == 1, i % 3 == 2, '0);
		video_flush();

		reset_during_paste();
		host_passthrough(8);

		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
